//--- bench/spi_patterns.txt
# address data wait_in_hold expected_old expected_packet (hex hex dec hex dec)
# expected_packet is 1 when the slave reports the write on access_out
00 a5 0 00 1
01 3c 3 00 1
27 7e 0 00 1
28 55 0 00 0
00 5a 5 a5 1
3f ff 2 00 0
01 c3 0 3c 1
27 81 4 7e 1
10 99 0 00 1
10 00 1 99 1
2a 11 0 00 0
00 0f 0 5a 1
1f e7 6 00 1
1f 18 0 e7 1

//--- spi_loopback.f
design/spi_pkg.sv
design/spi_if.sv
design/spi_master_fsm.sv
design/spi_bit_timer.sv
design/spi_master_shifter.sv
design/spi_slave.sv
design/spi_loopback_top.sv
bench/spi_loopback_checker.sv
bench/spi_loopback_tb.sv

//--- Bender.yml
package:
  name: spi_loopback

sources:
  - files:
      - design/spi_pkg.sv
      - design/spi_if.sv
      - design/spi_master_fsm.sv
      - design/spi_bit_timer.sv
      - design/spi_master_shifter.sv
      - design/spi_slave.sv
      - design/spi_loopback_top.sv
  - target: test
    files:
      - bench/spi_loopback_checker.sv
      - bench/spi_loopback_tb.sv

//--- bench/spi_loopback_tb.sv
`timescale 1ns/1ps

module spi_loopback_tb;
   import spi_pkg::*;

   // Conditions the stimulus can block on
   typedef enum {
      COND_WAIT_OUT_LOW,
      COND_RX_VALID,
      COND_ACCESS_OUT_HIGH,
      COND_ACCESS_OUT_LOW
   } wait_cond_e;

   logic             clk;
   logic             arst_n;
   logic             access_in;
   pkt_t             packet_in;
   logic             wait_out;
   logic             access_out;
   pkt_t             packet_out;
   logic             wait_in;
   logic             rx_valid;
   spi_byte_t        rx_data;

   // Test bookkeeping shared with the checker
   logic             test_done;
   int               test_idx;
   spi_byte_t        file_old;
   logic             file_out;
   int               pass_cnt;
   int               fail_cnt;

   int               seed;
   int               timeout_cycles;
   logic             timed_out;
   int               fd;
   int               code;
   int               fields;
   int               gap;
   logic [8*128-1:0] line_buf;
   logic [31:0]      pat_addr;
   logic [31:0]      pat_data;
   logic [31:0]      pat_old;
   int               pat_hold;
   int               pat_out;

   // ##########################################################
   // Clock, DUT and checker
   // ##########################################################
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   spi_loopback_top u_spi_loopback_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data)
   );

   spi_loopback_checker u_checker (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .test_done  (test_done),
      .test_idx   (test_idx),
      .file_old   (file_old),
      .file_out   (file_out),
      .pass_cnt   (pass_cnt),
      .fail_cnt   (fail_cnt)
   );

   // ##########################################################
   // Stimulus helpers
   // ##########################################################
   // Polls at the falling edge, gives up after timeout_cycles
   task automatic wait_until(input wait_cond_e cond, input string what);
      int   cycles;
      logic met;
      cycles = 0;
      met    = 1'b0;
      while (!met && !timed_out) begin
         @(negedge clk);
         case (cond)
            COND_WAIT_OUT_LOW:    met = !wait_out;
            COND_RX_VALID:        met = rx_valid;
            COND_ACCESS_OUT_HIGH: met = access_out;
            default:              met = !access_out;
         endcase
         cycles++;
         if (!met && cycles >= timeout_cycles) begin
            $display("Timeout in test %0d after %0d cycles waiting for %s",
                     test_idx, timeout_cycles, what);
            timed_out = 1'b1;
         end
      end
   endtask

   // One-cycle access strobe with a write packet
   task automatic send_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      packet_in = '0;
      packet_in[PKT_CTRL_MSB:PKT_CTRL_LSB] = PKT_CTRL_WR;
      packet_in[PKT_DST_LSB +: 32]  = addr;
      packet_in[PKT_DATA_LSB +: 32] = data;
      // Source field is ignored by the slave
      packet_in[PKT_SRC_LSB +: 32]  = $random(seed);
      access_in = 1'b1;
      @(posedge clk);
      #1;
      access_in = 1'b0;
   endtask

   // Full frame plus the output handshake for one pattern line
   task automatic run_pattern();
      wait_until(COND_WAIT_OUT_LOW, "wait_out low before the write");
      if (!timed_out)
         send_write(pat_addr, pat_data);
      wait_until(COND_RX_VALID, "rx_valid at frame end");
      // Stall the output side before the slave reports
      if (pat_hold > 0 && !timed_out) begin
         @(posedge clk);
         #1;
         wait_in = 1'b1;
         if (pat_out != 0)
            wait_until(COND_ACCESS_OUT_HIGH, "access_out under wait_in");
         repeat (pat_hold) @(posedge clk);
         #1;
         wait_in = 1'b0;
      end
      if (pat_out != 0) begin
         if (pat_hold == 0)
            wait_until(COND_ACCESS_OUT_HIGH, "access_out after the frame");
         wait_until(COND_ACCESS_OUT_LOW, "access_out to complete");
      end
      // Room for any stray output before the test closes
      repeat (6) @(posedge clk);
      #1;
      test_done = 1'b1;
      @(posedge clk);
      #1;
      test_done = 1'b0;
   endtask

   // ##########################################################
   // Main sequence
   // ##########################################################
   initial begin
      seed           = 32'h24074d9c;
      timeout_cycles = 400;
      timed_out      = 1'b0;
      arst_n         = 1'b0;
      access_in      = 1'b0;
      packet_in      = '0;
      wait_in        = 1'b0;
      test_done      = 1'b0;
      test_idx       = 0;
      file_old       = '0;
      file_out       = 1'b0;

      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      repeat (2) @(posedge clk);

      fd = $fopen("bench/spi_patterns.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the pattern file bench/spi_patterns.txt");
      end else begin
         while (!$feof(fd) && !timed_out) begin
            code = $fgets(line_buf, fd);
            // Comment lines do not parse into five fields
            fields = $sscanf(line_buf, "%h %h %d %h %d",
                             pat_addr, pat_data, pat_hold, pat_old, pat_out);
            if (code > 0 && fields == 5) begin
               test_idx++;
               file_old = pat_old[7:0];
               file_out = (pat_out != 0);
               run_pattern();
               if (pat_hold == 0) begin
                  gap = $unsigned($random(seed)) % 8;
                  repeat (gap) @(posedge clk);
               end
            end
         end
         $fclose(fd);
      end

      repeat (2) @(posedge clk);
      $display("Tests %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (timed_out || fd == 0 || test_idx == 0 || fail_cnt != 0) begin
         $display("Result: FAILED");
      end else begin
         $display("Result: PASSED");
      end
      $finish;
   end

endmodule

//--- bench/spi_loopback_checker.sv
`timescale 1ns/1ps

module spi_loopback_checker (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               access_in,
   input  spi_pkg::pkt_t      packet_in,
   input  logic               wait_out,
   input  logic               access_out,
   input  spi_pkg::pkt_t      packet_out,
   input  logic               wait_in,
   input  logic               rx_valid,
   input  spi_pkg::spi_byte_t rx_data,
   input  logic               test_done,
   input  int                 test_idx,
   input  spi_pkg::spi_byte_t file_old,
   input  logic               file_out,
   output int                 pass_cnt,
   output int                 fail_cnt
);
   import spi_pkg::*;

   // Reference copy of the slave registers
   spi_byte_t model [NUM_REGS];

   logic      reset_checked;
   logic      pending;
   logic      in_range;
   int        pend_addr;
   spi_byte_t pend_data;
   spi_byte_t exp_old;
   int        rx_cnt;
   int        out_cnt;
   int        test_err;
   logic      held;
   pkt_t      held_pkt;

   // ##########################################################
   // Reporting
   // ##########################################################
   task automatic compare_value(input string name, input logic [103:0] got,
                                input logic [103:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%0h expected 0x%0h in test %0d",
                  name, got, exp, test_idx);
         test_err++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("Error in test %0d %s", test_idx, msg);
      test_err++;
   endtask

   // One line per finished test
   task automatic close_test(input string label);
      if (test_err == 0) begin
         pass_cnt++;
         $display("%s ok", label);
      end else begin
         fail_cnt++;
         $display("%s had %0d error(s)", label, test_err);
      end
      test_err = 0;
   endtask

   initial begin
      pass_cnt = 0;
      fail_cnt = 0;
      test_err = 0;
   end

   // ##########################################################
   // Monitor, sampled mid-cycle where all ports are settled
   // ##########################################################
   always @(negedge clk) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_REGS; i++)
            model[i] = 8'h00;
         reset_checked = 1'b0;
         pending       = 1'b0;
         in_range      = 1'b1;
         exp_old       = 8'h00;
         rx_cnt        = 0;
         out_cnt       = 0;
         held          = 1'b0;
      end else begin
         // Idle outputs right after reset
         if (!reset_checked) begin
            compare_value("wait_out", wait_out, 0);
            compare_value("access_out", access_out, 0);
            compare_value("rx_valid", rx_valid, 0);
            reset_checked = 1'b1;
            close_test("test reset values");
         end

         // Request taken by the FSM on the coming edge
         if (access_in && !wait_out) begin
            pending   = 1'b1;
            pend_addr = packet_in[PKT_DST_LSB +: 6];
            pend_data = packet_in[PKT_DATA_LSB +: 8];
            in_range  = (pend_addr < NUM_REGS);
            exp_old   = in_range ? model[pend_addr] : 8'h00;
         end

         // Master sees the old byte or zeros
         if (rx_valid) begin
            rx_cnt++;
            compare_value("rx_data", rx_data, exp_old);
         end

         if (wait_in && !wait_out)
            report_error("wait_out was low while wait_in was high");

         // Stalled output held from the last cycle
         if (held) begin
            if (!access_out)
               report_error("access_out dropped while wait_in was high");
            compare_value("packet_out", packet_out, held_pkt);
         end

         if (access_out && !(pending && in_range)) begin
            report_error("access_out rose with no in-range write in flight");
         end else if (access_out && !wait_in) begin
            // Transfer completes on this cycle
            out_cnt++;
            compare_value("packet_out.ctrl", packet_out[PKT_CTRL_LSB +: 8], 8'h01);
            compare_value("packet_out.dst", packet_out[PKT_DST_LSB +: 32], pend_addr);
            compare_value("packet_out.data", packet_out[PKT_DATA_LSB +: 32], pend_data);
            compare_value("packet_out.src", packet_out[PKT_SRC_LSB +: 32], exp_old);
            model[pend_addr] = pend_data;
            pending          = 1'b0;
         end

         held     = access_out && wait_in;
         held_pkt = packet_out;

         if (test_done) begin
            if (rx_cnt != 1)
               report_error($sformatf("saw %0d rx_valid pulses instead of one", rx_cnt));
            if (out_cnt != (in_range ? 1 : 0))
               report_error($sformatf("saw %0d completed transfers", out_cnt));
            // Pattern file expectations against the model
            if (file_out !== in_range)
               report_error("pattern output flag disagrees with the address range");
            if (file_old !== exp_old)
               report_error("pattern old byte disagrees with the register model");
            close_test($sformatf("test %0d addr 0x%02h data 0x%02h",
                                 test_idx, pend_addr, pend_data));
            rx_cnt  = 0;
            out_cnt = 0;
            pending = 1'b0;
         end
      end
   end

endmodule

//--- design/spi_loopback_top.sv
`timescale 1ns/1ps

module spi_loopback_top (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               access_in,
   input  spi_pkg::pkt_t      packet_in,
   output logic               wait_out,
   output logic               access_out,
   output spi_pkg::pkt_t      packet_out,
   input  logic               wait_in,
   output logic               rx_valid,
   output spi_pkg::spi_byte_t rx_data
);

   logic start;
   logic done;
   logic frame_end;
   logic shift_edge;
   logic sample_edge;

   // Wires between master and slave
   spi_if spi_bus ();

   // ##########################################################
   // Master side
   // ##########################################################
   spi_master_fsm u_master_fsm (
      .clk       (clk),
      .arst_n    (arst_n),
      .access_in (access_in),
      .wait_in   (wait_in),
      .frame_end (frame_end),
      .wait_out  (wait_out),
      .start     (start),
      .done      (done),
      .spi       (spi_bus.master_ctrl)
   );

   spi_bit_timer u_bit_timer (
      .clk         (clk),
      .arst_n      (arst_n),
      .start       (start),
      .sclk        (spi_bus.sclk),
      .shift_edge  (shift_edge),
      .sample_edge (sample_edge),
      .frame_end   (frame_end)
   );

   spi_master_shifter u_master_shifter (
      .clk         (clk),
      .arst_n      (arst_n),
      .start       (start),
      .packet_in   (packet_in),
      .shift_edge  (shift_edge),
      .sample_edge (sample_edge),
      .done        (done),
      .mosi        (spi_bus.mosi),
      .miso        (spi_bus.miso),
      .rx_valid    (rx_valid),
      .rx_data     (rx_data)
   );

   // ##########################################################
   // Slave side
   // ##########################################################
   spi_slave u_slave (
      .clk        (clk),
      .arst_n     (arst_n),
      .spi        (spi_bus.slave),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

//--- design/spi_slave.sv
`timescale 1ns/1ps

module spi_slave (
   input  logic          clk,
   input  logic          arst_n,
   spi_if.slave          spi,
   input  logic          wait_in,
   output logic          access_out,
   output spi_pkg::pkt_t packet_out
);
   import spi_pkg::*;

   logic [1:0] sclk_sync;
   logic [1:0] mosi_sync;
   logic [1:0] ss_n_sync;
   logic       sclk_d;
   logic       ss_n_d;
   logic       sclk_rise;
   logic       sclk_fall;
   logic       ss_rise;
   logic       ss_fall;

   bit_cnt_t   rx_cnt;
   spi_byte_t  rx_sr;
   spi_byte_t  miso_sr;
   spi_byte_t  old_q;
   reg_addr_t  addr_q;
   logic       addr_ok_q;
   spi_byte_t  regs [NUM_REGS];

   spi_byte_t  addr_byte;
   logic       addr_ok;
   spi_byte_t  rd_byte;
   pkt_t       pkt_next;

   // ##########################################################
   // Synchronizers and edge detect
   // ##########################################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sclk_sync <= '0;
         mosi_sync <= '0;
         ss_n_sync <= 2'b11;
         sclk_d    <= 1'b0;
         ss_n_d    <= 1'b1;
      end else begin
         sclk_sync <= {sclk_sync[0], spi.sclk};
         mosi_sync <= {mosi_sync[0], spi.mosi};
         ss_n_sync <= {ss_n_sync[0], spi.ss_n};
         sclk_d    <= sclk_sync[1];
         ss_n_d    <= ss_n_sync[1];
      end
   end

   assign sclk_rise = sclk_sync[1] && !sclk_d;
   assign sclk_fall = !sclk_sync[1] && sclk_d;
   assign ss_rise   = ss_n_sync[1] && !ss_n_d;
   assign ss_fall   = !ss_n_sync[1] && ss_n_d;

   // ##########################################################
   // Frame decode
   // ##########################################################
   // Address byte as it completes on rising edge 8
   assign addr_byte = {rx_sr[6:0], mosi_sync[1]};
   assign addr_ok   = addr_byte < NUM_REGS;
   // Dropped addresses shift back zeros
   assign rd_byte   = addr_ok ? regs[reg_addr_t'(addr_byte)] : '0;

   // Output packet of a completed write
   always_comb begin
      pkt_next = '0;
      pkt_next[PKT_CTRL_MSB:PKT_CTRL_LSB]   = PKT_CTRL_WR;
      pkt_next[PKT_DST_LSB +: PKT_DST_W]   = PKT_DST_W'(addr_q);
      pkt_next[PKT_DATA_LSB +: PKT_DATA_W] = PKT_DATA_W'(rx_sr);
      pkt_next[PKT_SRC_LSB +: PKT_SRC_W]   = PKT_SRC_W'(old_q);
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_cnt     <= '0;
         rx_sr      <= '0;
         miso_sr    <= '0;
         old_q      <= '0;
         addr_q     <= '0;
         addr_ok_q  <= 1'b0;
         access_out <= 1'b0;
         packet_out <= '0;
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (ss_fall) begin
            rx_cnt  <= '0;
            miso_sr <= '0;
         end else if (!ss_n_sync[1]) begin
            if (sclk_rise && (rx_cnt != FRAME_BITS)) begin
               rx_sr  <= addr_byte;
               rx_cnt <= rx_cnt + 1'b1;
               // Address done, old byte ready before rising edge 9
               if (rx_cnt == FRAME_BITS / 2 - 1) begin
                  addr_q    <= reg_addr_t'(addr_byte);
                  addr_ok_q <= addr_ok;
                  old_q     <= rd_byte;
                  miso_sr   <= rd_byte;
               end
            end else if (sclk_fall && (rx_cnt > FRAME_BITS / 2)) begin
               // Data phase shifts back on falling sclk
               miso_sr <= {miso_sr[6:0], 1'b0};
            end
         end

         // Handshake done on a cycle with wait_in low
         if (access_out && !wait_in)
            access_out <= 1'b0;

         // Full frame closed by select, in range only
         if (ss_rise && (rx_cnt == FRAME_BITS) && addr_ok_q) begin
            regs[addr_q] <= rx_sr;
            packet_out   <= pkt_next;
            access_out   <= 1'b1;
         end
      end
   end

   assign spi.miso = miso_sr[7];

   // Stalled output must not move
   a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (access_out && wait_in) |=> (access_out && $stable(packet_out)))
      else $error("packet_out changed under wait_in");

endmodule

//--- design/spi_master_shifter.sv
`timescale 1ns/1ps

module spi_master_shifter (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               start,
   input  spi_pkg::pkt_t      packet_in,
   input  logic               shift_edge,
   input  logic               sample_edge,
   input  logic               done,
   output logic               mosi,
   input  logic               miso,
   output logic               rx_valid,
   output spi_pkg::spi_byte_t rx_data
);
   import spi_pkg::*;

   logic [FRAME_BITS-1:0] tx_sr;
   spi_byte_t             rx_sr;
   spi_byte_t             addr_byte;
   spi_byte_t             data_byte;

   // Register address zero extended to a byte
   assign addr_byte = spi_byte_t'(packet_in[PKT_DST_LSB +: $bits(reg_addr_t)]);
   assign data_byte = packet_in[PKT_DATA_LSB +: $bits(spi_byte_t)];

   // MSB first
   assign mosi      = tx_sr[FRAME_BITS-1];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_sr <= '0;
         rx_sr <= '0;
      end else if (start) begin
         tx_sr <= {addr_byte, data_byte};
         rx_sr <= '0;
      end else begin
         // Next bit goes out on falling sclk
         if (shift_edge)
            tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b0};
         // Last 8 samples are the slave's old byte
         if (sample_edge)
            rx_sr <= {rx_sr[6:0], miso};
      end
   end

   // Report with the frame done pulse
   assign rx_valid = done;
   assign rx_data  = rx_sr;

endmodule

//--- design/spi_bit_timer.sv
`timescale 1ns/1ps

module spi_bit_timer (
   input  logic clk,
   input  logic arst_n,
   input  logic start,
   output logic sclk,
   output logic shift_edge,
   output logic sample_edge,
   output logic frame_end
);
   import spi_pkg::*;

   logic                       active;
   logic [$clog2(CLK_DIV)-1:0] div_cnt;
   bit_cnt_t                   bit_cnt;
   logic                       half_done;

   // End of a half-period, none once all bits are out
   assign half_done   = active && (div_cnt == CLK_DIV - 1) && (bit_cnt != FRAME_BITS);
   // sclk low now, so this toggle is a rising edge
   assign sample_edge = half_done && !sclk;
   assign shift_edge  = half_done && sclk;
   // One cycle after the 16th falling edge
   assign frame_end   = active && (bit_cnt == FRAME_BITS);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         active  <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
         sclk    <= 1'b0;
      end else if (start) begin
         active  <= 1'b1;
         div_cnt <= '0;
         bit_cnt <= '0;
         sclk    <= 1'b0;
      end else if (frame_end) begin
         active  <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else if (active) begin
         if (half_done) begin
            div_cnt <= '0;
            sclk    <= !sclk;
            // Count a bit on each falling edge
            if (sclk)
               bit_cnt <= bit_cnt + 1'b1;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // Clock parks low between frames
   a_sclk_idle_low: assert property (@(posedge clk) disable iff (!arst_n)
      !active |-> !sclk)
      else $error("sclk high while timer idle");

endmodule

//--- design/spi_master_fsm.sv
`timescale 1ns/1ps

module spi_master_fsm (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       access_in,
   input  logic       wait_in,
   input  logic       frame_end,
   output logic       wait_out,
   output logic       start,
   output logic       done,
   spi_if.master_ctrl spi
);
   import spi_pkg::*;

   master_state_e state_q;
   master_state_e state_d;
   logic          accept;
   logic          finish;

   // Accept only from idle while the output side is free
   assign accept   = (state_q == ST_IDLE) && access_in && !wait_in;
   // Last falling edge seen while shifting
   assign finish   = (state_q == ST_SHIFT) && frame_end;

   // Start goes out in the accept cycle so the shifter loads on that edge
   assign start    = accept;
   // Busy from load until back in idle, or stalled downstream
   assign wait_out = (state_q != ST_IDLE) || wait_in;

   // ##########################################################
   // Next state
   // ##########################################################
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept)
               state_d = ST_SHIFT;
         end
         ST_SHIFT: begin
            if (frame_end)
               state_d = ST_DONE;
         end
         // One cycle to report, then idle again
         ST_DONE:  state_d = ST_IDLE;
         default:  state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q  <= ST_IDLE;
         done     <= 1'b0;
         spi.ss_n <= 1'b1;
      end else begin
         state_q <= state_d;
         done    <= finish;
         // Select drops with the load, rises after bit 16
         if (accept)
            spi.ss_n <= 1'b0;
         else if (finish)
            spi.ss_n <= 1'b1;
      end
   end

   // Stimulus must hold off while a frame is in flight
   a_no_access_busy: assert property (@(posedge clk) disable iff (!arst_n)
      (wait_out && (state_q != ST_IDLE)) |-> !access_in)
      else $error("access_in while master busy");

   // Timer frame end only lands while shifting, else done is lost
   a_frame_end_shift: assert property (@(posedge clk) disable iff (!arst_n)
      frame_end |-> (state_q == ST_SHIFT))
      else $error("frame_end outside ST_SHIFT");

endmodule

//--- design/spi_if.sv
`timescale 1ns/1ps

interface spi_if;

   // Serial clock, idles low (mode 0)
   logic sclk;
   // Master out, slave in
   logic mosi;
   // Slave select, active low
   logic ss_n;
   // Slave out, master in
   logic miso;

   // Master control side only owns slave select
   modport master_ctrl (output ss_n);

   // Slave sees the whole bundle and returns miso
   modport slave (
      input  sclk,
      input  mosi,
      input  ss_n,
      output miso
   );

endinterface

//--- design/spi_pkg.sv
package spi_pkg;

   // ##########################################################
   // Emesh packet layout
   // ##########################################################
   localparam int PKT_W        = 104;

   localparam int PKT_CTRL_LSB = 0;
   localparam int PKT_CTRL_MSB = 7;
   localparam int PKT_DST_LSB  = 8;
   localparam int PKT_DST_MSB  = 39;
   localparam int PKT_DATA_LSB = 40;
   localparam int PKT_DATA_MSB = 71;
   localparam int PKT_SRC_LSB  = 72;
   localparam int PKT_SRC_MSB  = 103;

   // Field widths derived from the layout
   localparam int PKT_DST_W    = PKT_DST_MSB - PKT_DST_LSB + 1;
   localparam int PKT_DATA_W   = PKT_DATA_MSB - PKT_DATA_LSB + 1;
   localparam int PKT_SRC_W    = PKT_SRC_MSB - PKT_SRC_LSB + 1;

   // Control value of a write, bit 0 set
   localparam logic [7:0] PKT_CTRL_WR = 8'h01;

   // ##########################################################
   // SPI link and slave sizing
   // ##########################################################
   localparam int NUM_REGS     = 40;
   localparam int FRAME_BITS   = 16;
   // clk cycles per sclk half-period
   localparam int CLK_DIV      = 4;

   typedef logic [PKT_W-1:0] pkt_t;
   typedef logic [7:0]       spi_byte_t;
   typedef logic [5:0]       reg_addr_t;
   typedef logic [4:0]       bit_cnt_t;

   // Master sequencing
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SHIFT,
      ST_DONE
   } master_state_e;

endpackage
